// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f ex_stage.f --top-module ex_stage_tb -Mdir obj_dir

run: compile
	./obj_dir/Vex_stage_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ex_stage.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_muldiv.sv
verilog/ex_csr.sv
verilog/ex_stage.sv
test/ex_stage_checker.sv
test/ex_stage_tb.sv

// File: test/ex_stage_checker.sv
//**********************************************************************
// ex_stage_checker
// watches the execute stage outputs and compares each result
// against a queue of expected write-back and redirect values
//**********************************************************************
`timescale 1ns/10ps

module ex_stage_checker (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        valid_i,
    input  logic        rd_we_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [63:0] rd_data_i,
    input  logic        redirect_i,
    input  logic [63:0] redirect_pc_i,
    input  logic        push_i,
    input  int          id_i,
    input  logic        we_i,
    input  logic [4:0]  rd_i,
    input  logic [63:0] data_i,
    input  logic        redir_i,
    input  logic [63:0] rpc_i,
    output int          pending_o,
    output int          err_cnt_o,
    output int          test_cnt_o
);

    typedef struct {
        int          id;
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        redir;
        logic [63:0] rpc;
    } exp_t;

    exp_t exp_q[$];
    int   mism;

    assign pending_o = exp_q.size();

    initial begin
        err_cnt_o  = 0;
        test_cnt_o = 0;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            mism++;
        end
    endtask

    // sampled on the falling edge, away from the drive and the register update
    always @(negedge clk_i) begin
        exp_t e;
        if (arst_n_i && valid_i) begin
            if (exp_q.size() == 0) begin
                $display("a result came out with no instruction waiting for it");
                err_cnt_o++;
            end else begin
                e    = exp_q.pop_front();
                mism = 0;
                compare("rd_we_o", 64'(rd_we_i), 64'(e.we));
                if (e.we) begin
                    compare("rd_addr_o", 64'(rd_addr_i), 64'(e.rd));
                    compare("rd_data_o", rd_data_i, e.data);
                end
                compare("redirect_o", 64'(redirect_i), 64'(e.redir));
                if (e.redir) begin
                    compare("redirect_pc_o", redirect_pc_i, e.rpc);
                end
                test_cnt_o++;
                if (mism == 0) begin
                    $display("test %0d ok", e.id);
                end else begin
                    $display("test %0d with %0d mismatches", e.id, mism);
                    err_cnt_o++;
                end
            end
        end
        if (arst_n_i && push_i) begin
            exp_q.push_back('{id_i, we_i, rd_i, data_i, redir_i, rpc_i});
        end
    end

endmodule

// File: test/ex_stage_tb.sv
//**********************************************************************
// ex_stage_tb
// testbench of the RV64 execute stage: clock and reset, a table of
// ALU, branch, CSR, trap and multiply/divide entries applied in a
// loop, and the expected values that go to the checker
//**********************************************************************
`timescale 1ns/10ps

module ex_stage_tb import ex_pkg::*; ();

    localparam logic [63:0] M1  = '1;
    localparam logic [63:0] MIN = {1'b1, 63'b0};
    localparam int          TIMEOUT = 200;

    typedef struct {
        ex_op_e      op;
        logic [63:0] pc;
        logic [63:0] op1;
        logic [63:0] op2;
        logic [63:0] imm;
        logic [4:0]  rd;
        logic        irq;
        logic        we;
        logic [63:0] data;
        logic        redir;
        logic [63:0] rpc;
    } entry_t;

    entry_t      tbl[$];
    logic [31:0] seed;
    int          tb_errs;
    int          wait_cnt;

    logic        clk;
    logic        arst_n;
    logic        valid_i;
    logic [63:0] pc_i;
    ex_op_e      op_i;
    logic [63:0] op1_i;
    logic [63:0] op2_i;
    logic [63:0] imm_i;
    logic [4:0]  rd_addr_i;
    logic        timer_irq_i;
    logic        valid_o;
    logic        rd_we_o;
    logic [4:0]  rd_addr_o;
    logic [63:0] rd_data_o;
    logic        redirect_o;
    logic [63:0] redirect_pc_o;
    logic        stall_o;

    logic        push;
    int          push_id;
    entry_t      cur;
    int          pending;
    int          err_cnt;
    int          test_cnt;

    ex_stage dut0 (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .op_i          (op_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .imm_i         (imm_i),
        .rd_addr_i     (rd_addr_i),
        .timer_irq_i   (timer_irq_i),
        .valid_o       (valid_o),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .stall_o       (stall_o)
    );

    ex_stage_checker chk0 (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .valid_i       (valid_o),
        .rd_we_i       (rd_we_o),
        .rd_addr_i     (rd_addr_o),
        .rd_data_i     (rd_data_o),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .push_i        (push),
        .id_i          (push_id),
        .we_i          (cur.we),
        .rd_i          (cur.rd),
        .data_i        (cur.data),
        .redir_i       (cur.redir),
        .rpc_i         (cur.rpc),
        .pending_o     (pending),
        .err_cnt_o     (err_cnt),
        .test_cnt_o    (test_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [63:0] rnd64();
        logic [31:0] hi;
        seed = xorshift(seed);
        hi   = seed;
        seed = xorshift(seed);
        return {hi, seed};
    endfunction

    function automatic logic is_md(input ex_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

    // reference results by the RISC-V M rules
    function automatic logic [63:0] md_model(input ex_op_e op, input logic [63:0] a,
                                             input logic [63:0] b);
        logic [127:0] p;
        logic         ovf;
        ovf = (a == MIN) && (b == M1);
        case (op)
            OP_MUL:   return a * b;
            OP_MULH: begin
                p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                return p[127:64];
            end
            OP_MULHU: begin
                p = {64'b0, a} * {64'b0, b};
                return p[127:64];
            end
            OP_DIV:   return (b == 0) ? M1 : ovf ? a : 64'($signed(a) / $signed(b));
            OP_REM:   return (b == 0) ? a : ovf ? 64'd0 : 64'($signed(a) % $signed(b));
            OP_DIVU:  return (b == 0) ? M1 : a / b;
            default:  return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic add(input ex_op_e op, input logic [63:0] pc, input logic [63:0] op1,
                       input logic [63:0] op2, input logic [63:0] imm, input logic [4:0] rd,
                       input logic irq, input logic we, input logic [63:0] data,
                       input logic redir, input logic [63:0] rpc);
        entry_t e;
        e = '{op, pc, op1, op2, imm, rd, irq, we, data, redir, rpc};
        tbl.push_back(e);
    endtask

    task automatic add_md(input ex_op_e op, input logic [63:0] a, input logic [63:0] b);
        add(op, 'h6000, a, b, 0, 9, 0, 1, md_model(op, a, b), 0, 0);
    endtask

    task automatic build_table();
        ex_op_e ops[7];
        ops = '{OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        // ALU ops back to back
        add(OP_ADD,  'h1000, 5, 7, 0, 1, 0, 1, 'hc, 0, 0);
        add(OP_SUB,  'h1000, 5, 7, 0, 1, 0, 1, 64'hffff_ffff_ffff_fffe, 0, 0);
        add(OP_SLT,  'h1000, M1, 1, 0, 1, 0, 1, 1, 0, 0);
        add(OP_SLTU, 'h1000, M1, 1, 0, 1, 0, 1, 0, 0, 0);
        add(OP_AND,  'h1000, 'hf0f0, 'hff00, 0, 1, 0, 1, 'hf000, 0, 0);
        add(OP_OR,   'h1000, 'hf0f0, 'h0f0f, 0, 1, 0, 1, 'hffff, 0, 0);
        add(OP_XOR,  'h1000, 'hff, 'h0f, 0, 1, 0, 1, 'hf0, 0, 0);
        add(OP_SLL,  'h1000, 1, 'h7f, 0, 1, 0, 1, MIN, 0, 0);
        add(OP_SRL,  'h1000, MIN, 4, 0, 1, 0, 1, 64'h0800_0000_0000_0000, 0, 0);
        add(OP_SRA,  'h1000, MIN, 4, 0, 1, 0, 1, 64'hf800_0000_0000_0000, 0, 0);
        add(OP_ADDW, 'h1000, 'h7fff_ffff, 1, 0, 1, 0, 1, 64'hffff_ffff_8000_0000, 0, 0);
        add(OP_SUBW, 'h1000, 64'h1_0000_0005, 6, 0, 1, 0, 1, M1, 0, 0);
        add(OP_LUI,  'h1000, 0, 64'hffff_ffff_1234_5000, 0, 1, 0, 1,
            64'hffff_ffff_1234_5000, 0, 0);
        // each branch taken then not taken
        add(OP_BEQ,  'h2000, 3, 3, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BEQ,  'h2000, 3, 4, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_BNE,  'h2000, 3, 4, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BNE,  'h2000, 3, 3, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_BLT,  'h2000, M1, 1, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BLT,  'h2000, 1, M1, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_BGE,  'h2000, 1, M1, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BGE,  'h2000, M1, 1, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_BLTU, 'h2000, 1, M1, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BLTU, 'h2000, M1, 1, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_BGEU, 'h2000, M1, 1, 'h40, 8, 0, 0, 0, 1, 'h2040);
        add(OP_BGEU, 'h2000, 1, M1, 'h40, 8, 0, 0, 0, 0, 0);
        add(OP_JAL,  'h3000, 0, 0, 'h100, 1, 0, 1, 'h3004, 1, 'h3100);
        add(OP_JAL,  'h3000, 0, 0, 'h100, 0, 0, 0, 0, 1, 'h3100);
        // CSR access returns the old value in rd
        add(OP_CSRRW, 'h3100, 'h8000, 0, CSR_MTVEC, 2, 0, 1, 0, 0, 0);
        add(OP_CSRRS, 'h3104, 'h0f, 0, CSR_MTVEC, 2, 0, 1, 'h8000, 0, 0);
        add(OP_CSRRC, 'h3108, 'h0f, 0, CSR_MTVEC, 2, 0, 1, 'h800f, 0, 0);
        add(OP_CSRRS, 'h310c, 0, 0, CSR_MTVEC, 2, 0, 1, 'h8000, 0, 0);
        add(OP_CSRRS, 'h3110, 0, 0, CSR_MTVEC, 2, 0, 1, 'h8000, 0, 0);
        add(OP_CSRRW, 'h3114, 5, 0, 'h7c0, 2, 0, 1, 0, 0, 0);
        add(OP_CSRRS, 'h3118, 0, 0, 'h7c0, 2, 0, 1, 0, 0, 0);
        // ECALL and MRET
        add(OP_ECALL, 'h4000, 0, 0, 0, 0, 0, 0, 0, 1, 'h8000);
        add(OP_CSRRS, 'h8000, 0, 0, CSR_MEPC, 3, 0, 1, 'h4000, 0, 0);
        add(OP_CSRRS, 'h8004, 0, 0, CSR_MCAUSE, 3, 0, 1, 'hb, 0, 0);
        add(OP_MRET,  'h8008, 0, 0, 0, 0, 0, 0, 0, 1, 'h4000);
        // timer interrupt taken once and then masked by the cleared MIE
        add(OP_CSRRW, 'h4000, 'h80, 0, CSR_MIE, 4, 0, 1, 0, 0, 0);
        add(OP_CSRRS, 'h4004, 'h08, 0, CSR_MSTATUS, 4, 0, 1, 'h80, 0, 0);
        add(OP_ADD,   'h5000, 1, 2, 0, 5, 1, 0, 0, 1, 'h8000);
        add(OP_CSRRS, 'h8000, 0, 0, CSR_MCAUSE, 6, 0, 1, {1'b1, 59'b0, 4'd7}, 0, 0);
        add(OP_ADD,   'h5010, 1, 2, 0, 7, 1, 1, 3, 0, 0);
        // multiply/divide edge cases and random operands
        add_md(OP_DIV, 'h1234, 0);
        add_md(OP_DIVU, 'h1234, 0);
        add_md(OP_REM, 'h1234, 0);
        add_md(OP_REMU, 'h1234, 0);
        add_md(OP_DIV, MIN, M1);
        add_md(OP_REM, MIN, M1);
        add_md(OP_MULH, M1, M1);
        for (int r = 0; r < 2; r++) begin
            foreach (ops[k]) begin
                add_md(ops[k], rnd64(), (r == 0) ? rnd64() : (rnd64() >> 29));
            end
        end
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    initial begin
        arst_n      = 1'b0;
        valid_i     = 1'b0;
        pc_i        = '0;
        op_i        = OP_NOP;
        op1_i       = '0;
        op2_i       = '0;
        imm_i       = '0;
        rd_addr_i   = '0;
        timer_irq_i = 1'b0;
        push        = 1'b0;
        push_id     = 0;
        cur         = '{OP_NOP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        tb_errs     = 0;
        seed        = 32'habb4;
        build_table();
        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;

        foreach (tbl[i]) begin
            @(posedge clk);
            #2;
            cur         = tbl[i];
            valid_i     = 1'b1;
            pc_i        = cur.pc;
            op_i        = cur.op;
            op1_i       = cur.op1;
            op2_i       = cur.op2;
            imm_i       = cur.imm;
            rd_addr_i   = cur.rd;
            timer_irq_i = cur.irq;
            push        = 1'b1;
            push_id     = i;
            if (is_md(cur.op)) begin
                @(negedge clk);
                if (stall_o !== 1'b1) begin
                    $display("stall did not rise when test %0d issued", i);
                    tb_errs++;
                end
                @(posedge clk);
                #2;
                valid_i = 1'b0;
                push    = 1'b0;
                wait_cnt = 0;
                while (stall_o) begin
                    @(negedge clk);
                    if (valid_o && stall_o) begin
                        $display("result of test %0d came while stall was high", i);
                        tb_errs++;
                    end
                    wait_cnt++;
                    if (wait_cnt > TIMEOUT) timeout("stall to fall");
                end
                if (!valid_o) begin
                    $display("stall fell before the result of test %0d", i);
                    tb_errs++;
                end
                wait_cnt = 0;
                while (!valid_o) begin
                    @(negedge clk);
                    wait_cnt++;
                    if (wait_cnt > TIMEOUT) timeout("a multiply/divide result");
                end
            end
        end

        @(posedge clk);
        #2;
        valid_i     = 1'b0;
        push        = 1'b0;
        timer_irq_i = 1'b0;
        wait_cnt    = 0;
        while (pending != 0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) timeout("the last results");
        end
        // idle cycles catch a stray second result
        repeat (5) @(posedge clk);

        $display("%0d entries, %0d checked, %0d failing, %0d other errors",
                 tbl.size(), test_cnt, err_cnt, tb_errs);
        if (err_cnt == 0 && tb_errs == 0 && test_cnt == tbl.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/ex_alu.sv
//********************************************************************
// ex_alu
// combinational integer ALU of the execute stage, with the
// comparator that resolves the six conditional branches
//********************************************************************
`timescale 1ns/10ps

module ex_alu import ex_pkg::*; (
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_taken_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_s;
    logic            lt_u;
    logic            eq;
    logic [5:0]      shamt;

    assign sum   = op1_i + op2_i;
    assign diff  = op1_i - op2_i;
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;
    assign eq    = op1_i == op2_i;
    assign shamt = op2_i[5:0];

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = sum;
            OP_SUB:  result_o = diff;
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            OP_AND:  result_o = op1_i & op2_i;
            OP_OR:   result_o = op1_i | op2_i;
            OP_XOR:  result_o = op1_i ^ op2_i;
            OP_SLL:  result_o = op1_i << shamt;
            OP_SRL:  result_o = op1_i >> shamt;
            // arithmetic shift fills with the sign bit
            OP_SRA:  result_o = $unsigned($signed(op1_i) >>> shamt);
            // word forms keep the low half and sign extend it
            OP_ADDW: result_o = {{(XLEN-32){sum[31]}}, sum[31:0]};
            OP_SUBW: result_o = {{(XLEN-32){diff[31]}}, diff[31:0]};
            // decode hands over the shifted immediate
            OP_LUI:  result_o = op2_i;
            OP_JAL:  result_o = pc_i + XLEN'(4);
            default: result_o = '0;
        endcase
    end

    // same compare terms as slt and sltu
    always_comb begin
        case (op_i)
            OP_BEQ:  branch_taken_o = eq;
            OP_BNE:  branch_taken_o = !eq;
            OP_BLT:  branch_taken_o = lt_s;
            OP_BGE:  branch_taken_o = !lt_s;
            OP_BLTU: branch_taken_o = lt_u;
            OP_BGEU: branch_taken_o = !lt_u;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

// File: verilog/ex_csr.sv
//********************************************************************
// ex_csr
// machine-mode CSRs (mstatus, mie, mtvec, mepc, mcause) with
// read-modify-write access, trap entry, MRET and timer trap
//********************************************************************
`timescale 1ns/10ps

module ex_csr import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  csr_cmd_e        cmd_i,
    input  logic [11:0]     addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            issue_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            ecall_i,
    input  logic            mret_i,
    input  logic            timer_irq_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            timer_trap_o,
    output logic [XLEN-1:0] trap_vector_o,
    output logic [XLEN-1:0] epc_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] wval;
    logic            we;
    logic            take_trap;

    always_comb begin
        case (addr_i)
            CSR_MSTATUS: rdata_o = mstatus_q;
            CSR_MIE:     rdata_o = mie_q;
            CSR_MTVEC:   rdata_o = mtvec_q;
            CSR_MEPC:    rdata_o = mepc_q;
            CSR_MCAUSE:  rdata_o = mcause_q;
            default:     rdata_o = '0;
        endcase
    end

    always_comb begin
        case (cmd_i)
            CSR_WRITE: wval = wdata_i;
            CSR_SET:   wval = rdata_o | wdata_i;
            CSR_CLEAR: wval = rdata_o & ~wdata_i;
            default:   wval = rdata_o;
        endcase
    end

    assign timer_trap_o = issue_i && timer_irq_i &&
                          mstatus_q[MSTATUS_MIE_BIT] && mie_q[MIE_MTIE_BIT];
    assign take_trap    = timer_trap_o | ecall_i;

    // set and clear with a zero mask only read
    assign we = ((cmd_i == CSR_WRITE) || ((cmd_i != CSR_NONE) && (wdata_i != '0))) &&
                !timer_trap_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (take_trap) begin
            mepc_q                      <= pc_i;
            mcause_q                    <= timer_trap_o ? CAUSE_TIMER_M : CAUSE_ECALL_M;
            mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (mret_i) begin
            mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (we) begin
            case (addr_i)
                CSR_MSTATUS: mstatus_q <= wval;
                CSR_MIE:     mie_q     <= wval;
                CSR_MTVEC:   mtvec_q   <= wval;
                CSR_MEPC:    mepc_q    <= wval;
                CSR_MCAUSE:  mcause_q  <= wval;
                default:     ;
            endcase
        end
    end

    // vectored mode is not supported, mtvec is the handler address
    assign trap_vector_o = mtvec_q;
    assign epc_o         = mepc_q;

endmodule

// File: verilog/ex_muldiv.sv
//********************************************************************
// ex_muldiv
// iterative multiply and divide unit: shift-add multiplier and
// restoring divider on one shared 128-bit accumulator, with the
// RISC-V results for divide by zero and signed overflow
//********************************************************************
`timescale 1ns/10ps

module ex_muldiv import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            start_i,
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] result_o,
    output logic            done_o,
    output logic            busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e                  state_q;
    logic [MULDIV_CNT_W-1:0] cnt_q;
    logic                    special_q;
    logic [2*XLEN-1:0]       acc_q;
    logic [XLEN-1:0]         b_q;
    ex_op_e                  op_q;
    logic                    neg_q;

    logic                    is_signed;
    logic                    is_div;
    logic                    a_neg;
    logic                    b_neg;
    logic [XLEN-1:0]         a_abs;
    logic [XLEN-1:0]         b_abs;
    logic                    div_zero;
    logic                    div_ovf;
    logic                    special;
    logic [XLEN-1:0]         special_val;

    logic                    run_div;
    logic [XLEN:0]           mul_sum;
    logic [XLEN:0]           rem_sh;
    logic                    rem_ge;
    logic [XLEN-1:0]         rem_diff;
    logic [2*XLEN-1:0]       acc_step;
    logic [2*XLEN-1:0]       prod_fix;
    logic [XLEN-1:0]         quot_fix;
    logic [XLEN-1:0]         rem_fix;

    // operands are turned into magnitudes before the loop
    assign is_signed = (op_i == OP_MULH) || (op_i == OP_DIV) || (op_i == OP_REM);
    assign is_div    = (op_i == OP_DIV) || (op_i == OP_DIVU) ||
                       (op_i == OP_REM) || (op_i == OP_REMU);
    assign a_neg     = is_signed & op1_i[XLEN-1];
    assign b_neg     = is_signed & op2_i[XLEN-1];
    assign a_abs     = a_neg ? -op1_i : op1_i;
    assign b_abs     = b_neg ? -op2_i : op2_i;

    assign div_zero  = is_div && (op2_i == '0);
    assign div_ovf   = ((op_i == OP_DIV) || (op_i == OP_REM)) &&
                       (op1_i == {1'b1, {(XLEN-1){1'b0}}}) && (op2_i == '1);
    assign special   = div_zero | div_ovf;

    always_comb begin
        if (div_zero) begin
            special_val = ((op_i == OP_DIV) || (op_i == OP_DIVU)) ? '1 : op1_i;
        end else begin
            special_val = (op_i == OP_DIV) ? op1_i : '0;
        end
    end

    // one iteration of either algorithm
    assign run_div  = (op_q == OP_DIV) || (op_q == OP_DIVU) ||
                      (op_q == OP_REM) || (op_q == OP_REMU);
    assign mul_sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, b_q};
    assign rem_sh   = acc_q[2*XLEN-1:XLEN-1];
    assign rem_ge   = rem_sh >= {1'b0, b_q};
    assign rem_diff = rem_sh[XLEN-1:0] - b_q;

    always_comb begin
        if (run_div) begin
            acc_step = rem_ge ? {rem_diff, acc_q[XLEN-2:0], 1'b1} : {acc_q[2*XLEN-2:0], 1'b0};
        end else begin
            acc_step = acc_q[0] ? {mul_sum, acc_q[XLEN-1:1]} : {1'b0, acc_q[2*XLEN-1:1]};
        end
    end

    // sign fix and half select
    assign prod_fix = neg_q ? -acc_q : acc_q;
    assign quot_fix = neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    assign rem_fix  = neg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    always_comb begin
        case (op_q)
            OP_MUL:            result_o = prod_fix[XLEN-1:0];
            OP_MULH, OP_MULHU: result_o = prod_fix[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:   result_o = quot_fix;
            default:           result_o = rem_fix;
        endcase
        if (special_q) begin
            result_o = acc_q[XLEN-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            cnt_q     <= '0;
            special_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        cnt_q     <= MULDIV_LAST;
                        special_q <= special;
                        state_q   <= special ? S_DONE : S_RUN;
                    end
                end
                S_RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_IDLE) && start_i) begin
            op_q  <= op_i;
            b_q   <= b_abs;
            // remainder takes the dividend's sign
            neg_q <= (op_i == OP_REM) ? a_neg : (a_neg ^ b_neg);
            acc_q <= {{XLEN{1'b0}}, special ? special_val : a_abs};
        end else if (state_q == S_RUN) begin
            acc_q <= acc_step;
        end
    end

    assign done_o = state_q == S_DONE;
    assign busy_o = state_q != S_IDLE;

endmodule

// File: verilog/ex_pkg.sv
//********************************************************************
// ex_pkg
// shared constants of the RV64 execute stage: register width,
// operation encoding, multiply/divide sizing, machine CSR
// addresses, status bit positions and trap causes
//********************************************************************
package ex_pkg;

    localparam int XLEN = 64;

    // multiply/divide iteration count and its step counter
    localparam int MULDIV_STEPS = 64;
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS);
    localparam logic [MULDIV_CNT_W-1:0] MULDIV_LAST = MULDIV_CNT_W'(MULDIV_STEPS - 1);

    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDW,
        OP_SUBW,
        OP_LUI,
        OP_JAL,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_MRET
    } ex_op_e;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = XLEN'(11);
    // interrupt flag in the top bit, machine timer code 7
    localparam logic [XLEN-1:0] CAUSE_TIMER_M = {1'b1, {(XLEN-4){1'b0}}, 3'd7};

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_cmd_e;

endpackage

// File: verilog/ex_stage.sv
//********************************************************************
// ex_stage
// execute stage top: issue and decode, CSR command decode,
// multiply/divide start and stall, result select and the
// registered write-back and PC redirect
//********************************************************************
`timescale 1ns/10ps

module ex_stage import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  ex_op_e          op_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [4:0]      rd_addr_i,
    input  logic            timer_irq_i,
    output logic            valid_o,
    output logic            rd_we_o,
    output logic [4:0]      rd_addr_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            stall_o
);

    logic            accept;
    logic            is_md;
    logic            is_csr;
    logic            writes_rd;
    csr_cmd_e        csr_cmd;
    logic            ecall;
    logic            mret;
    logic            md_start;
    logic            single;
    logic            jump;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] md_result;
    logic            md_done;
    logic            md_busy;
    logic [XLEN-1:0] csr_rdata;
    logic            timer_trap;
    logic [XLEN-1:0] trap_vector;
    logic [XLEN-1:0] epc;
    logic [4:0]      md_rd_q;

    // issue is dropped while a multiply/divide is in flight
    assign accept = valid_i & ~md_busy;

    always_comb begin
        is_md     = 1'b0;
        is_csr    = 1'b0;
        writes_rd = 1'b1;
        csr_cmd   = CSR_NONE;
        case (op_i)
            OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
                is_md = 1'b1;
            end
            OP_CSRRW: begin
                is_csr  = 1'b1;
                csr_cmd = CSR_WRITE;
            end
            OP_CSRRS: begin
                is_csr  = 1'b1;
                csr_cmd = CSR_SET;
            end
            OP_CSRRC: begin
                is_csr  = 1'b1;
                csr_cmd = CSR_CLEAR;
            end
            OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_ECALL, OP_MRET: begin
                writes_rd = 1'b0;
            end
            default: ;
        endcase
        if (!accept) begin
            csr_cmd = CSR_NONE;
        end
    end

    assign ecall    = accept && (op_i == OP_ECALL);
    assign mret     = accept && (op_i == OP_MRET);
    assign md_start = accept & is_md & ~timer_trap;
    assign single   = accept & ~md_start;
    assign stall_o  = md_start | md_busy;
    assign jump     = (op_i == OP_JAL) | branch_taken;

    always_comb begin
        if (timer_trap || ecall) begin
            redirect_pc = trap_vector;
        end else if (mret) begin
            redirect_pc = epc;
        end else begin
            redirect_pc = pc_i + imm_i;
        end
    end

    ex_alu u_alu (
        .op_i           (op_i),
        .pc_i           (pc_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    ex_muldiv u_muldiv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (md_start),
        .op_i     (op_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .result_o (md_result),
        .done_o   (md_done),
        .busy_o   (md_busy)
    );

    ex_csr u_csr (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .cmd_i         (csr_cmd),
        .addr_i        (imm_i[11:0]),
        .wdata_i       (op1_i),
        .issue_i       (accept),
        .pc_i          (pc_i),
        .ecall_i       (ecall),
        .mret_i        (mret),
        .timer_irq_i   (timer_irq_i),
        .rdata_o       (csr_rdata),
        .timer_trap_o  (timer_trap),
        .trap_vector_o (trap_vector),
        .epc_o         (epc)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o    <= 1'b0;
            rd_we_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else if (md_done) begin
            valid_o    <= 1'b1;
            rd_we_o    <= md_rd_q != 5'd0;
            redirect_o <= 1'b0;
        end else begin
            valid_o    <= single;
            // a timer trap cancels the write of the issued instruction
            rd_we_o    <= single & writes_rd & (rd_addr_i != 5'd0) & ~timer_trap;
            redirect_o <= accept & (timer_trap | ecall | mret | jump);
        end
    end

    always_ff @(posedge clk_i) begin
        if (md_start) begin
            md_rd_q <= rd_addr_i;
        end
        if (md_done) begin
            rd_addr_o <= md_rd_q;
            rd_data_o <= md_result;
        end else if (accept) begin
            rd_addr_o     <= rd_addr_i;
            rd_data_o     <= is_csr ? csr_rdata : alu_result;
            redirect_pc_o <= redirect_pc;
        end
    end

endmodule
